// File: hw/lq_params_pkg.sv
// load queue geometry constants shared by the memory-ordering checker
// sizes of the circular queue, its index and the word address

package lq_params_pkg;

	// ==========================================================================
	// queue geometry
	// ==========================================================================

	// entries in the circular load queue
	localparam int LQ_ENTRIES = 8;

	// width of a queue position (the count register is one bit wider)
	localparam int LQ_INDEX_WIDTH = 3;          // log2 of LQ_ENTRIES

	// ==========================================================================
	// address and port counts
	// ==========================================================================

	// loads and stores compare whole words, so no byte offset is carried
	localparam int ADDR_WIDTH = 16;

	// store resolve ports that can search the queue in the same cycle
	localparam int STORE_PORTS = 2;             // store_a and store_b at the top level

endpackage

// File: hw/lq_types_pkg.sv
// packed structs for the load queue traffic of executing loads, resolving
// stores and the per-port violation result

package lq_types_pkg;

	// ==========================================================================
	// load side
	// ==========================================================================

	// a load that has computed its address this cycle
	typedef struct packed {
		logic                                     valid;
		logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] lq_index;   // entry that executed
		logic [lq_params_pkg::ADDR_WIDTH-1:0]     addr;       // word address read
	} lq_exec_t;

	// ==========================================================================
	// store side
	// ==========================================================================

	// a store resolving its address on one of the store ports
	// lq_snapshot is the load queue tail at store dispatch, so every load at
	// or after that position is younger than the store
	typedef struct packed {
		logic                                     valid;
		logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] lq_snapshot;
		logic [lq_params_pkg::ADDR_WIDTH-1:0]     addr;       // word address written
	} store_resolve_t;

	// ==========================================================================
	// search result
	// ==========================================================================

	// outcome of one port's search, packed at the top level
	typedef struct packed {
		logic                                     valid;      // a younger load matched
		logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] lq_index;   // oldest such load
	} violation_t;

	// the flush controller sees the selected violation as flush_req and flush_index

endpackage

// File: hw/oldest_younger.sv
// combinational search of a circular queue for the oldest requesting entry
// at or after a target position, counted from the head
`timescale 1ns/1ps

module oldest_younger (
	input  logic [lq_params_pkg::LQ_ENTRIES-1:0]     req_vec,
	input  logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] head_index,
	input  logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] target_index,
	output logic                                     younger_present,
	output logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] oldest_younger_index
);

	logic [lq_params_pkg::LQ_ENTRIES-1:0]     head_mask;     // positions at or above the head
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     target_mask;   // positions at or above the target
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     eligible;
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     upper_vec;
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     lower_vec;
	logic                                     upper_present;
	logic                                     lower_present;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] upper_index;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] lower_index;

	always_comb begin
		for (int i = 0; i < lq_params_pkg::LQ_ENTRIES; i++) begin
			head_mask[i]   = lq_params_pkg::LQ_INDEX_WIDTH'(i) >= head_index;
			target_mask[i] = lq_params_pkg::LQ_INDEX_WIDTH'(i) >= target_index;
		end
	end

	// keep requests whose age distance from the head is at least the target's
	always_comb begin
		if (target_index >= head_index) begin
			// target sits in the upper segment, so the whole wrapped segment is younger
			eligible = req_vec & (target_mask | ~head_mask);
		end else begin
			// target has wrapped, only wrapped positions at or above it qualify
			eligible = req_vec & target_mask & ~head_mask;
		end
	end

	assign upper_vec = eligible & head_mask;     // from the head up to the top
	assign lower_vec = eligible & ~head_mask;    // wrapped part below the head

	// the downward scan leaves the lowest set bit of each segment
	always_comb begin
		upper_index = '0;
		lower_index = '0;
		for (int i = lq_params_pkg::LQ_ENTRIES - 1; i >= 0; i--) begin
			if (upper_vec[i])
				upper_index = lq_params_pkg::LQ_INDEX_WIDTH'(i);
			if (lower_vec[i])
				lower_index = lq_params_pkg::LQ_INDEX_WIDTH'(i);
		end
	end

	assign upper_present = |upper_vec;
	assign lower_present = |lower_vec;

	// anything in the upper segment is older than everything in the wrapped one
	assign younger_present      = upper_present | lower_present;
	assign oldest_younger_index = upper_present ? upper_index : lower_index;

endmodule

// File: hw/lq_entry_array.sv
// per-entry load state with head and tail pointers and occupancy count,
// plus the address match vector for each store port
`timescale 1ns/1ps

module lq_entry_array (
	input  logic                                     CLK,
	input  logic                                     nRST,
	input  logic                                     alloc_valid,
	output logic                                     alloc_ready,
	output logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] alloc_index,
	input  lq_types_pkg::lq_exec_t                   exec,
	input  logic                                     commit_valid,
	input  lq_types_pkg::store_resolve_t             store_a,
	input  lq_types_pkg::store_resolve_t             store_b,
	input  logic                                     rollback_valid,
	input  logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] rollback_index,
	output logic [lq_params_pkg::LQ_ENTRIES-1:0]     match_a,
	output logic [lq_params_pkg::LQ_ENTRIES-1:0]     match_b,
	output logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] head_index
);

	logic [lq_params_pkg::LQ_ENTRIES-1:0]     entry_valid;
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     entry_executed;
	logic [lq_params_pkg::ADDR_WIDTH-1:0]     entry_addr [lq_params_pkg::LQ_ENTRIES];
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] tail_ptr;
	logic [lq_params_pkg::LQ_INDEX_WIDTH:0]   count;     // one wider so full and empty differ
	logic                                     alloc_fire;
	logic                                     commit_fire;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] rollback_dist;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] entry_dist [lq_params_pkg::LQ_ENTRIES];
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     flush_mask;
	lq_types_pkg::store_resolve_t             store_port [lq_params_pkg::STORE_PORTS];
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     match_port [lq_params_pkg::STORE_PORTS];

	assign alloc_ready = count < lq_params_pkg::LQ_ENTRIES;
	assign alloc_index = tail_ptr;

	// a rollback cycle owns the pointers, so alloc and commit wait one cycle
	assign alloc_fire  = alloc_valid & alloc_ready & ~rollback_valid;
	assign commit_fire = commit_valid & (count != '0) & ~rollback_valid;

	// ==========================================================================
	// entries at least as young as the violating load are rolled back
	// ==========================================================================

	assign rollback_dist = rollback_index - head_index;

	always_comb begin
		for (int i = 0; i < lq_params_pkg::LQ_ENTRIES; i++) begin
			entry_dist[i] = lq_params_pkg::LQ_INDEX_WIDTH'(i) - head_index;
			flush_mask[i] = entry_dist[i] >= rollback_dist;
		end
	end

	// ==========================================================================
	// entry state and pointers
	// ==========================================================================

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			entry_valid    <= '0;
			entry_executed <= '0;
			head_index     <= '0;
			tail_ptr       <= '0;
			count          <= '0;
		end else if (rollback_valid) begin
			entry_valid    <= entry_valid & ~flush_mask;
			entry_executed <= entry_executed & ~flush_mask;
			tail_ptr       <= rollback_index;          // violating load is re-allocated here
			count          <= {1'b0, rollback_dist};
		end else begin
			if (alloc_fire) begin
				entry_valid[tail_ptr]    <= 1'b1;
				entry_executed[tail_ptr] <= 1'b0;
				tail_ptr                 <= tail_ptr + 1'b1;
			end
			if (exec.valid)
				entry_executed[exec.lq_index] <= 1'b1;
			if (commit_fire) begin
				entry_valid[head_index]    <= 1'b0;
				entry_executed[head_index] <= 1'b0;
				head_index                 <= head_index + 1'b1;
			end
			count <= count + (lq_params_pkg::LQ_INDEX_WIDTH + 1)'(alloc_fire)
				- (lq_params_pkg::LQ_INDEX_WIDTH + 1)'(commit_fire);
		end
	end

	// word address of each load, written when it executes
	always_ff @(posedge CLK) begin
		if (exec.valid)
			entry_addr[exec.lq_index] <= exec.addr;
	end

	// ==========================================================================
	// store address match vectors
	// ==========================================================================

	assign store_port[0] = store_a;
	assign store_port[1] = store_b;

	always_comb begin
		for (int p = 0; p < lq_params_pkg::STORE_PORTS; p++) begin
			for (int i = 0; i < lq_params_pkg::LQ_ENTRIES; i++) begin
				match_port[p][i] = store_port[p].valid & entry_valid[i] & entry_executed[i]
					& (entry_addr[i] == store_port[p].addr);
			end
		end
	end

	assign match_a = match_port[0];
	assign match_b = match_port[1];

endmodule

// File: hw/violation_select.sv
// selector that keeps the older of the two port violations and runs the
// four-phase flush handshake, followed by the queue rollback pulse
`timescale 1ns/1ps

module violation_select (
	input  logic                                     CLK,
	input  logic                                     nRST,
	input  logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] head_index,
	input  lq_types_pkg::violation_t                 viol_a,
	input  lq_types_pkg::violation_t                 viol_b,
	input  logic                                     accept,
	output logic                                     store_ready,
	output logic                                     flush_req,
	input  logic                                     flush_ack,
	output logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] flush_index,
	output logic                                     rollback_valid,
	output logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] rollback_index
);

	typedef enum logic [1:0] {
		state_idle,       // taking stores
		state_req,        // flush_req high, waiting for ack
		state_release     // ack seen, waiting for it to drop
	} sel_state_t;

	sel_state_t                               state;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] dist_a;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] dist_b;
	logic                                     pick_b;
	logic                                     any_viol;
	logic                                     capture;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] chosen_index;

	// ==========================================================================
	// age compare where the smaller distance from the head is the older load
	// ==========================================================================

	assign dist_a = viol_a.lq_index - head_index;
	assign dist_b = viol_b.lq_index - head_index;

	// on a tie both ports point at the same load, so port a is kept
	assign pick_b       = viol_b.valid & (~viol_a.valid | (dist_b < dist_a));
	assign chosen_index = pick_b ? viol_b.lq_index : viol_a.lq_index;
	assign any_viol     = viol_a.valid | viol_b.valid;
	assign capture      = accept & any_viol;

	// ==========================================================================
	// flush handshake
	// ==========================================================================

	assign store_ready    = state == state_idle;      // low through req and release
	assign flush_req      = state == state_req;
	assign rollback_index = flush_index;

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			state          <= state_idle;
			rollback_valid <= 1'b0;
		end else begin
			rollback_valid <= 1'b0;   // single cycle pulse
			case (state)
				state_idle: begin
					if (capture)
						state <= state_req;
				end
				state_req: begin
					if (flush_ack) begin
						state          <= state_release;
						rollback_valid <= 1'b1;   // same edge that drops flush_req
					end
				end
				state_release: begin
					if (~flush_ack)
						state <= state_idle;
				end
				default: state <= state_idle;
			endcase
		end
	end

	// index held stable for the whole request phase
	always_ff @(posedge CLK) begin
		if (capture)
			flush_index <= chosen_index;
	end

endmodule

// File: hw/mem_order_check.sv
// top level of the load queue ordering checker with the entry array,
// one oldest-younger search per store port and the violation selector
`timescale 1ns/1ps

module mem_order_check (
	input  logic                                     CLK,
	input  logic                                     nRST,
	input  logic                                     alloc_valid,
	output logic                                     alloc_ready,
	output logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] alloc_index,
	input  lq_types_pkg::lq_exec_t                   exec,
	input  logic                                     commit_valid,
	input  lq_types_pkg::store_resolve_t             store_a,
	input  lq_types_pkg::store_resolve_t             store_b,
	output logic                                     store_ready,
	output logic                                     flush_req,
	output logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] flush_index,
	input  logic                                     flush_ack
);

	logic [lq_params_pkg::LQ_ENTRIES-1:0]     match_a;
	logic [lq_params_pkg::LQ_ENTRIES-1:0]     match_b;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] head_index;
	logic                                     found_a;
	logic                                     found_b;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] index_a;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] index_b;
	lq_types_pkg::violation_t                 viol_a;
	lq_types_pkg::violation_t                 viol_b;
	logic                                     accept;
	logic                                     rollback_valid;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] rollback_index;

	// ==========================================================================
	// queue state and address compare
	// ==========================================================================

	lq_entry_array entries (
		.CLK(CLK), .nRST(nRST),
		.alloc_valid(alloc_valid), .alloc_ready(alloc_ready), .alloc_index(alloc_index),
		.exec(exec), .commit_valid(commit_valid),
		.store_a(store_a), .store_b(store_b),
		.rollback_valid(rollback_valid), .rollback_index(rollback_index),
		.match_a(match_a), .match_b(match_b), .head_index(head_index)
	);

	// each search starts at the tail its store saw at dispatch
	oldest_younger search_a (
		.req_vec(match_a), .head_index(head_index), .target_index(store_a.lq_snapshot),
		.younger_present(found_a), .oldest_younger_index(index_a)
	);

	oldest_younger search_b (
		.req_vec(match_b), .head_index(head_index), .target_index(store_b.lq_snapshot),
		.younger_present(found_b), .oldest_younger_index(index_b)
	);

	assign viol_a = '{valid: found_a, lq_index: index_a};
	assign viol_b = '{valid: found_b, lq_index: index_b};
	assign accept = store_ready & (store_a.valid | store_b.valid);   // a store lands this edge

	violation_select select (
		.CLK(CLK), .nRST(nRST), .head_index(head_index),
		.viol_a(viol_a), .viol_b(viol_b), .accept(accept), .store_ready(store_ready),
		.flush_req(flush_req), .flush_ack(flush_ack), .flush_index(flush_index),
		.rollback_valid(rollback_valid), .rollback_index(rollback_index)
	);

endmodule

// File: sim/mem_order_check_tb.sv
// stimulus table, queue reference model and flush controller model for the
// load queue ordering checker, with value checks and a cycle timeout
`timescale 1ns/1ps

module mem_order_check_tb;

	typedef struct packed {
		logic [2:0]                               test;
		logic                                     alloc;
		logic                                     commit;
		lq_types_pkg::lq_exec_t                   exec;
		lq_types_pkg::store_resolve_t             sa;
		lq_types_pkg::store_resolve_t             sb;
		logic                                     exp_flush;   // a violation is expected
		logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] exp_index;
	} row_t;

	logic                                     CLK;
	logic                                     nRST;
	logic                                     alloc_valid;
	logic                                     alloc_ready;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] alloc_index;
	lq_types_pkg::lq_exec_t                   exec;
	logic                                     commit_valid;
	lq_types_pkg::store_resolve_t             store_a;
	lq_types_pkg::store_resolve_t             store_b;
	logic                                     store_ready;
	logic                                     flush_req;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] flush_index;
	logic                                     flush_ack;

	row_t                                     rows [$];
	row_t                                     cur;          // inputs of the current cycle
	logic                                     model_valid [lq_params_pkg::LQ_ENTRIES];
	logic                                     model_exec [lq_params_pkg::LQ_ENTRIES];
	logic [lq_params_pkg::ADDR_WIDTH-1:0]     model_addr [lq_params_pkg::LQ_ENTRIES];
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] model_head;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] model_tail;
	logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] pred_index;
	int                                       model_count;
	int                                       dist_a;
	int                                       dist_b;
	int                                       pick;         // age distance of the winner or -1
	int                                       cycles;
	int                                       cycle_limit;
	int                                       ack_delay;
	int                                       errors;
	int                                       test_errors;
	int                                       failed_tests;
	string test_names [1:5] = '{"reset and fill", "single port older/younger",
		"oldest of several younger", "dual port with wrap", "alloc after rollback"};

	mem_order_check DUT (.*);

	assign alloc_valid  = cur.alloc;
	assign exec         = cur.exec;
	assign commit_valid = cur.commit;
	assign store_a      = cur.sa;
	assign store_b      = cur.sb;

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// the flush controller raises ack on the second cycle that it sees flush_req
	always @(posedge CLK) begin
		#2;
		if (flush_req && !flush_ack) begin
			ack_delay = ack_delay + 1;
			if (ack_delay == 2)
				flush_ack = 1'b1;
		end else if (!flush_req) begin
			ack_delay = 0;
			flush_ack = 1'b0;     // release phase
		end
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic add_row(input int test, input bit alloc, input bit commit, input bit ev,
			input int eidx, input int eaddr, input bit av, input int asnap, input int aaddr,
			input bit bv, input int bsnap, input int baddr, input bit flush, input int fidx);
		row_t r;
		r.test      = 3'(test);
		r.alloc     = alloc;
		r.commit    = commit;
		r.exec      = '{valid: ev, lq_index: lq_params_pkg::LQ_INDEX_WIDTH'(eidx),
			addr: lq_params_pkg::ADDR_WIDTH'(eaddr)};
		r.sa        = '{valid: av, lq_snapshot: lq_params_pkg::LQ_INDEX_WIDTH'(asnap),
			addr: lq_params_pkg::ADDR_WIDTH'(aaddr)};
		r.sb        = '{valid: bv, lq_snapshot: lq_params_pkg::LQ_INDEX_WIDTH'(bsnap),
			addr: lq_params_pkg::ADDR_WIDTH'(baddr)};
		r.exp_flush = flush;
		r.exp_index = lq_params_pkg::LQ_INDEX_WIDTH'(fidx);
		rows.push_back(r);
	endtask

	// reference search returning the age distance of the oldest matching load
	// at or after the snapshot
	function automatic int younger_dist(input lq_types_pkg::store_resolve_t st);
		logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] idx;
		logic [lq_params_pkg::LQ_INDEX_WIDTH-1:0] snap_dist;
		int                                       found;
		found     = -1;
		snap_dist = st.lq_snapshot - model_head;
		for (int d = lq_params_pkg::LQ_ENTRIES - 1; d >= 0; d--) begin
			idx = model_head + lq_params_pkg::LQ_INDEX_WIDTH'(d);
			if (d >= int'(snap_dist) && model_valid[idx] && model_exec[idx]
					&& model_addr[idx] == st.addr)
				found = d;
		end
		return found;
	endfunction

	// ========================================================================
	// stimulus table
	// ========================================================================

	task automatic build_table();
		add_row(1, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);    // entry 0
		add_row(1, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(1, 1, 0, 1, 1, 'h11, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(1, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(1, 1, 0, 1, 3, 'h33, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(1, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(1, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(1, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);    // queue now full
		add_row(1, 1, 1, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);    // alloc refused
		add_row(2, 0, 0, 0, 0, 'h00, 1, 2, 'h11, 0, 0, 'h00, 0, 0);    // load 1 is older
		add_row(2, 0, 0, 0, 0, 'h00, 1, 2, 'h33, 0, 0, 'h00, 1, 3);
		add_row(3, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(3, 1, 0, 1, 3, 'h44, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(3, 1, 0, 1, 4, 'h77, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(3, 1, 0, 1, 5, 'h77, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(3, 1, 0, 1, 6, 'h77, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(3, 0, 0, 0, 0, 'h00, 1, 5, 'h77, 0, 0, 'h00, 1, 5);    // 4 matches but is older
		add_row(4, 1, 1, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(4, 1, 1, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(4, 1, 1, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);    // head reaches 4
		add_row(4, 1, 0, 1, 6, 'h99, 0, 0, 'h00, 0, 0, 'h00, 0, 0);    // entry 0 after the wrap
		add_row(4, 1, 0, 1, 0, 'h99, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(4, 0, 0, 1, 1, 'hAA, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(4, 0, 0, 0, 0, 'h00, 1, 0, 'hAA, 1, 5, 'h99, 1, 6);    // port b is older
		add_row(5, 1, 0, 0, 0, 'h00, 0, 0, 'h00, 0, 0, 'h00, 0, 0);
		add_row(5, 0, 0, 0, 0, 'h00, 1, 6, 'h99, 0, 0, 'h00, 0, 0);    // cleared entries
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		cur          = '0;
		flush_ack    = 1'b0;
		nRST         = 1'b0;
		cycles       = 0;
		ack_delay    = 0;
		errors       = 0;
		test_errors  = 0;
		failed_tests = 0;
		build_table();
		cycle_limit = rows.size() * 10;
		for (int i = 0; i < lq_params_pkg::LQ_ENTRIES; i++) begin
			model_valid[i] = 1'b0;
			model_exec[i]  = 1'b0;
		end
		model_head  = '0;
		model_tail  = '0;
		model_count = 0;
		repeat (4) @(posedge CLK);
		#2 nRST = 1'b1;
		compare("flush_req", flush_req, 0);
		compare("store_ready", store_ready, 1);
		foreach (rows[r]) begin
			compare("alloc_ready", alloc_ready, model_count < lq_params_pkg::LQ_ENTRIES);
			compare("alloc_index", alloc_index, model_tail);
			dist_a     = rows[r].sa.valid ? younger_dist(rows[r].sa) : -1;
			dist_b     = rows[r].sb.valid ? younger_dist(rows[r].sb) : -1;
			pick       = (dist_b >= 0 && (dist_a < 0 || dist_b < dist_a)) ? dist_b : dist_a;
			pred_index = model_head + lq_params_pkg::LQ_INDEX_WIDTH'(pick);
			cur        = rows[r];
			if (cur.alloc && model_count < lq_params_pkg::LQ_ENTRIES) begin
				model_valid[model_tail] = 1'b1;
				model_exec[model_tail]  = 1'b0;
				model_tail              = model_tail + 1'b1;
				model_count++;
			end
			if (cur.exec.valid) begin
				model_exec[cur.exec.lq_index] = 1'b1;
				model_addr[cur.exec.lq_index] = cur.exec.addr;
			end
			if (cur.commit && model_count > 0) begin
				model_valid[model_head] = 1'b0;
				model_exec[model_head]  = 1'b0;
				model_head              = model_head + 1'b1;
				model_count--;
			end
			@(posedge CLK);
			#2 cur = '0;
			if (rows[r].sa.valid || rows[r].sb.valid) begin
				compare("flush_req", flush_req, pick >= 0);
				compare("model_flush", pick >= 0, rows[r].exp_flush);
			end
			if (pick >= 0) begin
				compare("flush_index", flush_index, rows[r].exp_index);
				compare("model_flush_index", pred_index, rows[r].exp_index);
				compare("store_ready", store_ready, 0);
				while (!store_ready) begin    // stores held until the handshake ends
					@(posedge CLK);
					#2;
				end
				// the violating load and every younger entry up to the old tail are dropped
				for (int k = pick; k < model_count; k++) begin
					model_valid[model_head + lq_params_pkg::LQ_INDEX_WIDTH'(k)] = 1'b0;
					model_exec[model_head + lq_params_pkg::LQ_INDEX_WIDTH'(k)]  = 1'b0;
				end
				model_count = pick;
				model_tail  = pred_index;
				compare("alloc_index", alloc_index, rows[r].exp_index);
			end
			if (r == rows.size() - 1 || rows[r + 1].test != rows[r].test) begin
				$display("test %0d %s: %s", rows[r].test, test_names[rows[r].test],
					test_errors == 0 ? "ok" : "failed");
				if (test_errors != 0)
					failed_tests++;
				test_errors = 0;
			end
		end
		$display("tests run 5, tests failed %0d, check errors %0d", failed_tests, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: build.f
hw/lq_params_pkg.sv
hw/lq_types_pkg.sv
hw/oldest_younger.sv
hw/lq_entry_array.sv
hw/violation_select.sv
hw/mem_order_check.sv
sim/mem_order_check_tb.sv

// File: Bender.yml
package:
  name: mem_order_check

sources:
  - hw/lq_params_pkg.sv
  - hw/lq_types_pkg.sv
  - hw/oldest_younger.sv
  - hw/lq_entry_array.sv
  - hw/violation_select.sv
  - hw/mem_order_check.sv
  - target: test
    files:
      - sim/mem_order_check_tb.sv
